// ==== src/strAccelPkg.sv ====
// Shared types, register addresses and control-bit positions for the string accelerator
`default_nettype none

package strAccelPkg;

	typedef logic [31:0] wordT;     // Avalon data word
	typedef logic [7:0]  byteT;     // One character
	typedef logic [2:0]  posT;      // Byte position or window length
	typedef logic [2:0]  regAddrT;  // Register address
	typedef logic [3:0]  laneMaskT; // One bit per byte lane

	localparam int numLanes = 4; // Fixed by the 32-bit bus word

	// LSB of each control register field
	localparam int ctrlDone     = 0;  // Read-only status
	localparam int ctrlGo       = 1;  // Write-one strobe that reads 0
	localparam int ctrlIndex    = 2;  // Bits 4..2
	localparam int ctrlLength   = 5;  // Bits 7..5
	localparam int ctrlMask     = 8;  // Read-only bits 11..8
	localparam int ctrlAllMatch = 12; // Read-only

	// Register map where addresses 4..7 read as zero
	localparam regAddrT regA      = 3'd0;
	localparam regAddrT regB      = 3'd1;
	localparam regAddrT regCtrl   = 3'd2;
	localparam regAddrT regResult = 3'd3;

endpackage

`default_nettype wire

// ==== src/strLaneIf.sv ====
// Per-lane bundle between the register block, one byte lane and the result collector
`timescale 1ns/1ps
`default_nettype none

interface strLaneIf;
	import strAccelPkg::*;

	logic start;   // One-cycle go strobe
	byteT aByte;   // Byte of A for this position
	byteT bByte;   // Byte of B for this position
	logic active;  // Position lies inside the window

	byteT outByte; // Spliced byte
	logic match;   // Case-insensitive compare result
	logic valid;   // Lane outputs updated

	// Register block side
	modport feeder (output start, aByte, bByte, active);

	// The lane itself
	modport lane (input start, aByte, bByte, active, output outByte, match, valid);

	// Collector side
	modport drain (input outByte, match, valid);

endinterface

`default_nettype wire

// ==== src/strAvalonRegs.sv ====
// Avalon-MM register block that holds A, B and control, fires go and feeds the byte lanes
`timescale 1ns/1ps
`default_nettype none

module strAvalonRegs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   chipselect,
	input  logic                   read,
	input  logic                   write,
	input  strAccelPkg::regAddrT   address,
	input  strAccelPkg::wordT      writedata,
	output strAccelPkg::wordT      readdata,
	strLaneIf.feeder               lanes [strAccelPkg::numLanes],
	input  strAccelPkg::wordT      resultWord,
	input  strAccelPkg::laneMaskT  matchMask,
	input  logic                   allMatch,
	input  logic                   done
);
	import strAccelPkg::*;

	wordT     aReg, bReg;       // Operand words
	posT      indexReg;         // Window start
	posT      lengthReg;        // Window length
	logic     startReg;         // Go strobe toward the lanes
	laneMaskT activeMask;       // Lanes inside the window
	logic [3:0] windowEnd;      // index + length in one extra bit so it cannot wrap
	wordT     ctrlWord;         // Assembled control read value

	logic wrA, wrB, wrCtrl;     // Write decode
	logic rdStrobe;             // Any read cycle

	assign wrA      = chipselect && write && (address == regA);
	assign wrB      = chipselect && write && (address == regB);
	assign wrCtrl   = chipselect && write && (address == regCtrl);
	assign rdStrobe = chipselect && read;

	// Operand registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			aReg <= '0;
			bReg <= '0;
		end else begin
			if (wrA) aReg <= writedata;
			if (wrB) bReg <= writedata;
		end
	end

	// Control fields and go strobe
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			indexReg  <= '0;
			lengthReg <= '0;
			startReg  <= 1'b0;
		end else begin
			startReg <= wrCtrl && writedata[ctrlGo]; // Single cycle per accepted go
			if (wrCtrl) begin
				indexReg  <= writedata[ctrlIndex +: $bits(posT)];
				lengthReg <= writedata[ctrlLength +: $bits(posT)];
			end
		end
	end

	assign windowEnd = {1'b0, indexReg} + {1'b0, lengthReg};

	// Lane i active when index <= i < index + length
	always_comb begin
		for (int i = 0; i < numLanes; i++) begin
			activeMask[i] = (4'(i) >= {1'b0, indexReg}) && (4'(i) < windowEnd);
		end
	end

	// Fan the operands out with byte 0 in bits 7..0
	for (genvar g = 0; g < numLanes; g++) begin : genFeed
		assign lanes[g].start  = startReg;
		assign lanes[g].aByte  = aReg[8*g +: 8];
		assign lanes[g].bByte  = bReg[8*g +: 8];
		assign lanes[g].active = activeMask[g];
	end

	// Control word where the go bit always reads 0
	always_comb begin
		ctrlWord                               = '0;
		ctrlWord[ctrlDone]                     = done && !startReg; // Done drops as soon as go lands
		ctrlWord[ctrlIndex +: $bits(posT)]     = indexReg;
		ctrlWord[ctrlLength +: $bits(posT)]    = lengthReg;
		ctrlWord[ctrlMask +: numLanes]         = matchMask;
		ctrlWord[ctrlAllMatch]                 = allMatch;
	end

	// Registered read data with latency 1
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			readdata <= '0;
		end else if (rdStrobe) begin
			case (address)
				regA:      readdata <= aReg;
				regB:      readdata <= bReg;
				regCtrl:   readdata <= ctrlWord;
				regResult: readdata <= resultWord;
				default:   readdata <= '0; // Unmapped space
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/strByteLane.sv ====
// One byte lane that splices B into A and compares the two bytes ignoring ASCII case
`timescale 1ns/1ps
`default_nettype none

module strByteLane (
	input logic     clk,
	input logic     reset,
	strLaneIf.lane  lane
);
	import strAccelPkg::*;

	byteT aLower; // A folded to lower case
	byteT bLower; // B folded to lower case

	// Fold ASCII A..Z to a..z and pass other codes
	function automatic byteT foldCase(input byteT c);
		byteT r;
		r = c;
		if (c >= 8'h41 && c <= 8'h5A) begin
			r = c | 8'h20; // Set the case bit
		end
		return r;
	endfunction

	assign aLower = foldCase(lane.aByte);
	assign bLower = foldCase(lane.bByte);

	// Valid trails start by one cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lane.valid <= 1'b0;
		end else begin
			lane.valid <= lane.start;
		end
	end

	// Capture byte and match bit on start
	always_ff @(posedge clk) begin
		if (lane.start) begin
			lane.outByte <= lane.active ? lane.bByte : lane.aByte; // Splice inside window
			if (lane.active) begin
				lane.match <= (aLower == bLower);
			end else begin
				lane.match <= 1'b1; // Outside the window never fails
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/strResultCollect.sv ====
// Collects the lane outputs into the result word, match mask, all-match flag and done
`timescale 1ns/1ps
`default_nettype none

module strResultCollect (
	input  logic                   clk,
	input  logic                   reset,
	strLaneIf.drain                lanes [strAccelPkg::numLanes],
	input  logic                   start,
	output strAccelPkg::wordT      resultWord,
	output strAccelPkg::laneMaskT  matchMask,
	output logic                   allMatch,
	output logic                   done
);
	import strAccelPkg::*;

	byteT [numLanes-1:0] laneBytes; // Lane 0 lands in bits 7..0
	laneMaskT            laneMatch;
	logic                laneValid; // Lane 0 stands for all lanes since they step together

	for (genvar g = 0; g < numLanes; g++) begin : genGather
		assign laneBytes[g] = lanes[g].outByte;
		assign laneMatch[g] = lanes[g].match;
	end

	assign laneValid = lanes[0].valid;

	// Result and status registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			resultWord <= '0;
			matchMask  <= '0;
			allMatch   <= 1'b0;
		end else if (laneValid) begin
			resultWord <= laneBytes;
			matchMask  <= laneMatch;
			allMatch   <= &laneMatch; // Every lane agrees
		end
	end

	// Done tracks the latest go
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b0; // New go wins over an older finish
		end else if (laneValid) begin
			done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/strAccelTop.sv ====
// String accelerator top level with plain Avalon-MM slave ports
`timescale 1ns/1ps
`default_nettype none

module strAccelTop (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  chipselect,
	input  logic                  read,
	input  logic                  write,
	input  strAccelPkg::regAddrT  address,
	input  strAccelPkg::wordT     writedata,
	output strAccelPkg::wordT     readdata
);
	import strAccelPkg::*;

	strLaneIf laneBus [numLanes] (); // One bundle per byte position

	wordT     resultWord; // Collector to register block
	laneMaskT matchMask;
	logic     allMatch;
	logic     done;

	strAvalonRegs uRegs (
		.clk        (clk),
		.reset      (reset),
		.chipselect (chipselect),
		.read       (read),
		.write      (write),
		.address    (address),
		.writedata  (writedata),
		.readdata   (readdata),
		.lanes      (laneBus),
		.resultWord (resultWord),
		.matchMask  (matchMask),
		.allMatch   (allMatch),
		.done       (done)
	);

	for (genvar g = 0; g < numLanes; g++) begin : genLane
		strByteLane uLane (
			.clk   (clk),
			.reset (reset),
			.lane  (laneBus[g])
		);
	end

	strResultCollect uCollect (
		.clk        (clk),
		.reset      (reset),
		.lanes      (laneBus),
		.start      (laneBus[0].start), // Same strobe on every lane
		.resultWord (resultWord),
		.matchMask  (matchMask),
		.allMatch   (allMatch),
		.done       (done)
	);

endmodule

`default_nettype wire

// ==== bench/strAccel_sva.sv ====
// Protocol assertions on go, lane valid and done that bind into the lanes and the collector
`timescale 1ns/1ps
`default_nettype none

module handshakeChecks (
	input logic clk,
	input logic reset,
	input logic start,  // Go strobe as seen by the bound module
	input logic valid,  // Lane valid
	input logic done    // Collector done that a lane ties low
);

	// Lane outputs land exactly one cycle after the strobe
	validAfterStart: assert property (@(posedge clk) disable iff (reset) start |=> valid)
		else $error("valid did not follow start");

	validOnlyAfterStart: assert property (@(posedge clk) disable iff (reset)
		valid |-> $past(start))
		else $error("valid without start one cycle earlier");

	// Done comes from a lane valid that no newer go overrode
	doneAfterValid: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $past(valid && !start))
		else $error("done rose without lane valid one cycle earlier");

	// Go is a single-cycle pulse
	singleStart: assert property (@(posedge clk) disable iff (reset) start |=> !start)
		else $error("start high for two cycles in a row");

endmodule

bind strByteLane handshakeChecks laneChecks (
	.clk   (clk),
	.reset (reset),
	.start (lane.start),
	.valid (lane.valid),
	.done  (1'b0)         // No done inside a lane
);

bind strResultCollect handshakeChecks collectChecks (
	.clk   (clk),
	.reset (reset),
	.start (start),
	.valid (laneValid),
	.done  (done)
);

`default_nettype wire

// ==== bench/strAccelTb.sv ====
// Testbench for strAccelTop that drives Avalon cycles and checks the splice and case-blind compare
`timescale 1ns/1ps
`default_nettype none

module strAccelTb;
	import strAccelPkg::*;

	typedef struct packed {
		wordT a;
		wordT b;
		posT  index;
		posT  length;
		wordT result; // Result register after done
		wordT ctrl;   // Control word read after the result
	} obsT;

	logic    clk;
	logic    reset;
	logic    chipselect;
	logic    read;
	logic    write;
	regAddrT address;
	wordT    writedata;
	wordT    readdata;

	logic [31:0] lfsrState = 32'h6674;
	obsT         obsQ [$]; // Observed runs waiting for the compare process

	strAccelTop dut_i (
		.clk        (clk),
		.reset      (reset),
		.chipselect (chipselect),
		.read       (read),
		.write      (write),
		.address    (address),
		.writedata  (writedata),
		.readdata   (readdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	task automatic stopRun();
		$display("TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s actual 0x%h expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkMask(input string name, input laneMaskT actual, input laneMaskT expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s actual 0x%h expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s actual 0x%h expected 0x%h", name, actual, expected);
			stopRun();
		end
	endtask

	// Taps of x^32 + x^22 + x^2 + x + 1 with a left shift
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic wordT randBits(input int n);
		wordT r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic wordT randLetters();
		wordT w;
		byteT c;
		w = '0;
		for (int i = 0; i < numLanes; i++) begin
			c = byteT'(32'h41 + (randBits(5) % 32'd26)); // Upper case A..Z
			if (randBits(1) == 32'd1) begin
				c = c + 8'h20; // Some lower case
			end
			w[8*i +: 8] = c;
		end
		return w;
	endfunction

	function automatic byteT lowerAscii(input byteT c);
		if (c >= "A" && c <= "Z") begin
			return c + 8'd32;
		end
		return c;
	endfunction

	// Flips letter case and leaves other codes alone
	function automatic wordT swapCase(input wordT w);
		wordT r;
		byteT c;
		for (int i = 0; i < numLanes; i++) begin
			c = w[8*i +: 8];
			if (c >= "A" && c <= "Z") c = c + 8'd32;
			else if (c >= "a" && c <= "z") c = c - 8'd32;
			r[8*i +: 8] = c;
		end
		return r;
	endfunction

	// Expected splice word, match mask and all-match for one window
	function automatic void spliceRef(input wordT a, input wordT b, input posT index,
		input posT length, output wordT word, output laneMaskT mask, output logic all);
		int first;
		int stop;
		byteT aB;
		byteT bB;
		first = int'(index);
		stop  = first + int'(length); // The loop cuts off a window past lane 3
		word  = a;
		mask  = '1;                    // Lanes outside the window always match
		for (int i = 0; i < numLanes; i++) begin
			aB = a[8*i +: 8];
			bB = b[8*i +: 8];
			if (i >= first && i < stop) begin
				word[8*i +: 8] = bB;
				mask[i] = (lowerAscii(aB) == lowerAscii(bB));
			end
		end
		all = &mask;
	endfunction

	function automatic wordT goCmd(input posT index, input posT length);
		wordT w;
		w = '0;
		w[ctrlGo] = 1'b1;
		w[ctrlIndex +: 3]  = index;
		w[ctrlLength +: 3] = length;
		return w;
	endfunction

	// Single write cycle entered and left on a rising edge
	task automatic busWrite(input regAddrT addr, input wordT data);
		chipselect <= 1'b1;
		write      <= 1'b1;
		address    <= addr;
		writedata  <= data;
		@(posedge clk);          // Slave takes the write here
		chipselect <= 1'b0;
		write      <= 1'b0;
	endtask

	task automatic busRead(input regAddrT addr, output wordT data);
		chipselect <= 1'b1;
		read       <= 1'b1;
		address    <= addr;
		@(posedge clk);          // readdata registered on this edge
		chipselect <= 1'b0;
		read       <= 1'b0;
		@(negedge clk);
		data = readdata;         // Stable mid-cycle
		@(posedge clk);
	endtask

	task automatic waitDone();
		wordT ctrl;
		int   polls;
		polls = 0;
		busRead(regCtrl, ctrl);
		while (!ctrl[ctrlDone]) begin
			polls++;
			if (polls > 20) begin
				$display("Done bit never came back within 20 control reads after go");
				stopRun();
			end
			busRead(regCtrl, ctrl);
		end
	endtask

	// Read result and status, then queue the run for comparison
	task automatic recordRun(input wordT a, input wordT b, input posT index,
		input posT length);
		obsT o;
		wordT result;
		wordT ctrl;
		busRead(regResult, result);
		busRead(regCtrl, ctrl);
		o.a      = a;
		o.b      = b;
		o.index  = index;
		o.length = length;
		o.result = result;
		o.ctrl   = ctrl;
		obsQ.push_back(o);
	endtask

	task automatic runCase(input wordT a, input wordT b, input posT index, input posT length);
		busWrite(regA, a);
		busWrite(regB, b);
		busWrite(regCtrl, goCmd(index, length));
		waitDone();
		recordRun(a, b, index, length);
	endtask

	// Compare process that works off the queue mid-cycle
	always @(negedge clk) begin
		obsT      o;
		wordT     expWord;
		laneMaskT expMask;
		logic     expAll;
		wordT     expCtrl;
		while (obsQ.size() > 0) begin
			o = obsQ.pop_front();
			spliceRef(o.a, o.b, o.index, o.length, expWord, expMask, expAll);
			checkWord("result", o.result, expWord);
			checkMask("ctrl.mask", o.ctrl[ctrlMask +: numLanes], expMask);
			checkFlag("ctrl.allMatch", o.ctrl[ctrlAllMatch], expAll);
			expCtrl                       = '0;
			expCtrl[ctrlDone]             = 1'b1; // Done holds until the next go
			expCtrl[ctrlIndex +: 3]       = o.index;
			expCtrl[ctrlLength +: 3]      = o.length;
			expCtrl[ctrlMask +: numLanes] = expMask;
			expCtrl[ctrlAllMatch]         = expAll;
			checkWord("ctrl", o.ctrl, expCtrl);
		end
	end

	initial begin
		wordT rd;
		wordT a;
		wordT b;
		int   k;
		reset      <= 1'b1;
		chipselect <= 1'b0;
		read       <= 1'b0;
		write      <= 1'b0;
		address    <= '0;
		writedata  <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Reset values
		busRead(regCtrl, rd);
		checkWord("ctrl after reset", rd, '0);
		busRead(regResult, rd);
		checkWord("result after reset", rd, '0);

		// Register readback and unmapped space
		a = randBits(32);
		b = randBits(32);
		busWrite(regA, a);
		busWrite(regB, b);
		busRead(regA, rd);
		checkWord("regA", rd, a);
		busRead(regB, rd);
		checkWord("regB", rd, b);
		for (int addr = 4; addr < 8; addr++) begin
			busRead(regAddrT'(addr), rd);
			checkWord("unmapped", rd, '0);
		end
		busWrite(regCtrl, goCmd(3'd1, 3'd2));
		busRead(regCtrl, rd);
		checkFlag("ctrl.go", rd[ctrlGo], 1'b0); // Strobe never reads back
		waitDone();
		recordRun(a, b, 3'd1, 3'd2);

		// Every window with three kinds of operand pair
		for (int idx = 0; idx < 8; idx++) begin
			for (int len = 0; len < 8; len++) begin
				case ((idx + len) % 3)
					0: begin
						a = randBits(32);
						b = randBits(32);
					end
					1: begin
						a = randLetters();
						b = swapCase(a);   // Same text in the other case
					end
					default: begin
						a = randLetters();
						b = swapCase(a);
						k = int'(randBits(2));
						b[8*k +: 8] = byteT'(randBits(8)); // One byte likely differs
					end
				endcase
				runCase(a, b, posT'(idx), posT'(len));
			end
		end

		// Restart with a second go and a new length one idle cycle after the first
		a = randLetters();
		b = swapCase(randLetters());
		busWrite(regA, a);
		busWrite(regB, b);
		busWrite(regCtrl, goCmd(3'd0, 3'd1));
		@(posedge clk);
		busWrite(regCtrl, goCmd(3'd0, 3'd4));
		waitDone();
		recordRun(a, b, 3'd0, 3'd4);

		// A rewritten while the operation runs
		a = randBits(32);
		b = randBits(32);
		busWrite(regA, a);
		busWrite(regB, b);
		busWrite(regCtrl, goCmd(3'd1, 3'd2));
		busWrite(regA, ~a);
		waitDone();
		recordRun(a, b, 3'd1, 3'd2);
		busRead(regA, rd);
		checkWord("regA after late write", rd, ~a);

		// Let the compare process catch up
		k = 0;
		while (obsQ.size() > 0) begin
			k++;
			if (k > 10) begin
				$display("Compare queue did not drain within 10 cycles");
				stopRun();
			end
			@(posedge clk);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/strAccelPkg.sv
src/strLaneIf.sv
src/strAvalonRegs.sv
src/strByteLane.sv
src/strResultCollect.sv
src/strAccelTop.sv
bench/strAccel_sva.sv
bench/strAccelTb.sv

// ==== Makefile ====
# Verilator build and run of the string accelerator testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module strAccelTb \
		-f compile.f -o strAccelSim
	./obj_dir/strAccelSim

clean:
	rm -rf obj_dir
